//--- build.f
+incdir+src
src/immu_pkg.sv
src/immu_req_decode.sv
src/itlb.sv
src/ptw.sv
src/xlate_result.sv
src/immu_top.sv
verif/immu_properties.sv
verif/immu_mem_model.sv
verif/immu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module immu_tb -o immu_sim
./obj_dir/immu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    exit 1
fi

//--- src/immu_pkg.sv
package immu_pkg;

    // Sv32 page table entry, leaf and pointer share this layout
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic       valid;
        logic       page_4m;
        logic [9:0] vpn_1;
        logic [9:0] vpn_0;
        pte_t       pte;
    } tlb_entry_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [3:0]  tag;
    } xlate_req_t;

    typedef struct packed {
        logic [3:0]  tag;
        logic [21:0] ppn;
        logic        page_4m;
        logic        page_fault;
    } xlate_rsp_t;

    // Refill from the walker
    typedef struct packed {
        logic [19:0] vpn;
        pte_t        pte;
        logic        page_4m;
    } walk_fill_t;

    typedef struct packed {
        logic [33:0] addr;  // Physical byte address
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
    } mem_rd_rsp_t;

endpackage

//--- src/immu_req_decode.sv
`include "immu_settings.svh"

module immu_req_decode
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  xlate_req_t  req,
    output logic        req_credit,
    output logic        lookup_valid,
    output logic [19:0] lookup_vpn,
    output logic [3:0]  lookup_tag,
    input  logic        tlb_hit,
    output logic        walk_start,
    input  logic        walk_done,
    input  logic        rsp_issue
);

    localparam int DEPTH = `IMMU_REQ_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WALKING,
        ST_RETRY
    } state_t;

    state_t           state_q;
    state_t           state_d;
    xlate_req_t       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             push;
    logic             pop;

    // Credits bound the queue, so a push never finds it full
    assign push    = req_valid;
    assign pop     = rsp_issue;  // Head leaves when its response is formed
    assign count_d = count_q + CNT_W'(push) - CNT_W'(pop);

    assign lookup_valid = (state_q == ST_LOOKUP) || (state_q == ST_RETRY);
    assign lookup_vpn   = fifo_mem[rd_ptr_q].vpn;
    assign lookup_tag   = fifo_mem[rd_ptr_q].tag;

    always_comb begin
        state_d    = state_q;
        walk_start = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (push) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP, ST_RETRY: begin
                if (tlb_hit) begin
                    state_d = (count_d != '0) ? ST_LOOKUP : ST_IDLE;
                end else begin
                    // Miss, also after a fill lost to a flush
                    walk_start = 1'b1;
                    state_d    = ST_WALKING;
                end
            end
            ST_WALKING: begin
                if (walk_done) begin
                    if (rsp_issue) begin  // Walk fault answers directly
                        state_d = (count_d != '0) ? ST_LOOKUP : ST_IDLE;
                    end else begin
                        state_d = ST_RETRY;  // Fill lands this edge
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            req_credit <= 1'b0;
        end else begin
            state_q    <= state_d;
            count_q    <= count_d;
            req_credit <= rsp_issue;  // Lines up with rsp_valid
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= req;
        end
    end

endmodule

//--- src/immu_settings.svh
`ifndef IMMU_SETTINGS_SVH
`define IMMU_SETTINGS_SVH

// Direct-mapped, must stay a power of two
`define IMMU_TLB_ENTRIES 4

// Fetch side starts with this many request credits
`define IMMU_REQ_CREDITS 2

// Outstanding page table reads the walker may hold
`define IMMU_MEM_CREDITS 2

`endif

//--- src/immu_top.sv
module immu_top
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [21:0] satp_ppn,
    input  logic        flush,
    input  logic        req_valid,
    input  xlate_req_t  req,
    output logic        req_credit,
    output logic        rsp_valid,
    output xlate_rsp_t  rsp,
    output logic        mem_req_valid,
    output mem_rd_req_t mem_req,
    input  logic        mem_rsp_valid,
    input  mem_rd_rsp_t mem_rsp
);

    logic        lookup_valid;
    logic [19:0] lookup_vpn;
    logic [3:0]  lookup_tag;
    logic        tlb_hit;
    pte_t        hit_pte;
    logic        hit_page_4m;
    logic        walk_start;
    logic        walk_done;
    logic        walk_fault;
    logic        fill_valid;
    walk_fill_t  fill;
    logic        rsp_issue;

    immu_req_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .req_credit   (req_credit),
        .lookup_valid (lookup_valid),
        .lookup_vpn   (lookup_vpn),
        .lookup_tag   (lookup_tag),
        .tlb_hit      (tlb_hit),
        .walk_start   (walk_start),
        .walk_done    (walk_done),
        .rsp_issue    (rsp_issue)
    );

    itlb u_itlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_vpn   (lookup_vpn),
        .hit          (tlb_hit),
        .hit_pte      (hit_pte),
        .hit_page_4m  (hit_page_4m),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .flush        (flush)
    );

    ptw u_ptw (
        .clk           (clk),
        .rst_n         (rst_n),
        .satp_ppn      (satp_ppn),
        .walk_start    (walk_start),
        .walk_vpn      (lookup_vpn),  // Head request is the one walked
        .walk_done     (walk_done),
        .walk_fault    (walk_fault),
        .fill_valid    (fill_valid),
        .fill          (fill),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    xlate_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .hit         (tlb_hit),
        .hit_pte     (hit_pte),
        .hit_page_4m (hit_page_4m),
        .walk_fault  (walk_fault),
        .walk_done   (walk_done),
        .lookup_vpn  (lookup_vpn),
        .lookup_tag  (lookup_tag),
        .rsp_issue   (rsp_issue),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

//--- src/itlb.sv
`include "immu_settings.svh"

module itlb
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        lookup_valid,
    input  logic [19:0] lookup_vpn,
    output logic        hit,
    output pte_t        hit_pte,
    output logic        hit_page_4m,
    input  logic        fill_valid,
    input  walk_fill_t  fill,
    input  logic        flush
);

    localparam int ENTRIES = `IMMU_TLB_ENTRIES;
    localparam int IDX_W   = $clog2(ENTRIES);

    tlb_entry_t       tlb_q [ENTRIES];
    tlb_entry_t       tlb_d [ENTRIES];
    tlb_entry_t       rd_entry;
    logic [IDX_W-1:0] sp_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             sp_sel;

    // Superpages sit at the low vpn_1 bits, 4 KiB pages at the low vpn_0 bits
    assign sp_idx   = lookup_vpn[10 +: IDX_W];
    assign sp_sel   = tlb_q[sp_idx].valid && tlb_q[sp_idx].page_4m;
    assign rd_idx   = sp_sel ? sp_idx : lookup_vpn[IDX_W-1:0];
    assign rd_entry = tlb_q[rd_idx];

    always_comb begin
        hit         = 1'b0;
        hit_pte     = '0;
        hit_page_4m = 1'b0;
        if (lookup_valid && rd_entry.valid &&
            (rd_entry.vpn_1 == lookup_vpn[19:10]) &&
            (rd_entry.page_4m || (rd_entry.vpn_0 == lookup_vpn[9:0]))) begin
            hit         = 1'b1;
            hit_pte     = rd_entry.pte;
            hit_page_4m = rd_entry.page_4m;
        end
    end

    // Write slot follows the same indexing as the read side
    assign wr_idx = fill.page_4m ? fill.vpn[10 +: IDX_W] : fill.vpn[IDX_W-1:0];

    always_comb begin
        tlb_d = tlb_q;
        if (flush) begin  // sfence.vma wins over a refill
            for (int i = 0; i < ENTRIES; i++) begin
                tlb_d[i].valid = 1'b0;
            end
        end else if (fill_valid) begin
            tlb_d[wr_idx].valid   = 1'b1;
            tlb_d[wr_idx].page_4m = fill.page_4m;
            tlb_d[wr_idx].vpn_1   = fill.vpn[19:10];
            tlb_d[wr_idx].vpn_0   = fill.vpn[9:0];
            tlb_d[wr_idx].pte     = fill.pte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tlb_q[i] <= '0;
            end
        end else begin
            tlb_q <= tlb_d;
        end
    end

endmodule

//--- src/ptw.sv
`include "immu_settings.svh"

module ptw
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [21:0] satp_ppn,
    input  logic        walk_start,
    input  logic [19:0] walk_vpn,
    output logic        walk_done,
    output logic        walk_fault,
    output logic        fill_valid,
    output walk_fill_t  fill,
    output logic        mem_req_valid,
    output mem_rd_req_t mem_req,
    input  logic        mem_rsp_valid,
    input  mem_rd_rsp_t mem_rsp
);

    localparam int CRED_W = $clog2(`IMMU_MEM_CREDITS + 1);

    typedef enum logic [1:0] {
        PW_IDLE,
        PW_REQ,
        PW_WAIT
    } pw_state_t;

    pw_state_t         state_q;
    logic              lvl1_q;          // Set while reading level 1
    logic [CRED_W-1:0] mem_credits_q;
    logic [19:0]       walk_vpn_q;
    logic [33:0]       addr_q;
    logic              mem_issue;
    pte_t              rd_pte;
    logic              is_leaf;
    logic              bad_pte;

    assign mem_issue     = (state_q == PW_REQ) && (mem_credits_q != '0);
    assign mem_req_valid = mem_issue;
    assign mem_req.addr  = addr_q;

    // Entry classification
    assign rd_pte  = pte_t'(mem_rsp.data);
    assign is_leaf = rd_pte.r || rd_pte.x;
    assign bad_pte = !rd_pte.v
                   || (rd_pte.w && !rd_pte.r)   // Reserved encoding
                   || (is_leaf && !rd_pte.x)    // Not executable
                   || (!is_leaf && !lvl1_q);    // Pointer at level 0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= PW_IDLE;
            lvl1_q        <= 1'b1;
            mem_credits_q <= CRED_W'(`IMMU_MEM_CREDITS);
            walk_done     <= 1'b0;
            walk_fault    <= 1'b0;
            fill_valid    <= 1'b0;
        end else begin
            walk_done  <= 1'b0;
            walk_fault <= 1'b0;
            fill_valid <= 1'b0;
            case ({mem_issue, mem_rsp_valid})
                2'b10:   mem_credits_q <= mem_credits_q - 1'b1;
                2'b01:   mem_credits_q <= mem_credits_q + 1'b1;
                default: mem_credits_q <= mem_credits_q;
            endcase
            case (state_q)
                PW_IDLE: begin
                    if (walk_start) begin
                        lvl1_q  <= 1'b1;
                        state_q <= PW_REQ;
                    end
                end
                PW_REQ: begin
                    if (mem_issue) state_q <= PW_WAIT;  // Stalls without credit
                end
                PW_WAIT: begin
                    if (mem_rsp_valid) begin
                        if (bad_pte || is_leaf) begin
                            walk_done  <= 1'b1;
                            walk_fault <= bad_pte;
                            fill_valid <= !bad_pte;
                            state_q    <= PW_IDLE;
                        end else begin
                            lvl1_q  <= 1'b0;  // Descend to level 0
                            state_q <= PW_REQ;
                        end
                    end
                end
                default: state_q <= PW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == PW_IDLE) && walk_start) begin
            walk_vpn_q <= walk_vpn;
            addr_q     <= {satp_ppn, 12'h000} + 34'({walk_vpn[19:10], 2'b00});
        end else if ((state_q == PW_WAIT) && mem_rsp_valid) begin
            addr_q       <= {rd_pte.ppn, 12'h000} + 34'({walk_vpn_q[9:0], 2'b00});
            fill.vpn     <= walk_vpn_q;
            fill.pte     <= rd_pte;
            fill.page_4m <= lvl1_q;  // Leaf at level 1 maps 4 MiB
        end
    end

endmodule

//--- src/xlate_result.sv
module xlate_result
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hit,
    input  pte_t        hit_pte,
    input  logic        hit_page_4m,
    input  logic        walk_fault,
    input  logic        walk_done,
    input  logic [19:0] lookup_vpn,
    input  logic [3:0]  lookup_tag,
    output logic        rsp_issue,
    output logic        rsp_valid,
    output xlate_rsp_t  rsp
);

    // A response is formed on a hit or on a faulting walk
    assign rsp_issue = hit || (walk_done && walk_fault);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_issue) begin
            rsp.tag <= lookup_tag;
            if (hit) begin
                // Superpage takes vpn_0 as its low page bits
                rsp.ppn        <= hit_page_4m ? {hit_pte.ppn[21:10], lookup_vpn[9:0]}
                                              : hit_pte.ppn;
                rsp.page_4m    <= hit_page_4m;
                rsp.page_fault <= 1'b0;
            end else begin
                rsp.ppn        <= '0;
                rsp.page_4m    <= 1'b0;
                rsp.page_fault <= 1'b1;
            end
        end
    end

endmodule

//--- verif/immu_mem_model.sv
module immu_mem_model
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req_valid,
    input  mem_rd_req_t mem_req,
    output logic        mem_rsp_valid,
    output mem_rd_rsp_t mem_rsp
);

    localparam int MEM_WORDS = 16384;  // 64 KiB of page table space
    localparam int LATENCY   = 3;

    logic [31:0]        mem [MEM_WORDS];
    logic [LATENCY-1:0] vld_q;
    logic [31:0]        data_q [LATENCY];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;  // Every entry starts invalid
        end
    end

    // Backdoor write used to build the page tables
    task automatic write_word(input logic [33:0] addr, input logic [31:0] data);
        mem[addr[15:2]] = data;
    endtask

    // Valid pulse doubles as the returned credit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LATENCY-2:0], mem_req_valid};
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= mem[mem_req.addr[15:2]];
        for (int i = 1; i < LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign mem_rsp_valid = vld_q[LATENCY-1];
    assign mem_rsp.data  = data_q[LATENCY-1];

endmodule

//--- verif/immu_properties.sv
`include "immu_settings.svh"

module immu_properties
    import immu_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       req_valid,
    input logic       req_credit,
    input logic       rsp_valid,
    input xlate_rsp_t rsp,
    input logic       mem_req_valid,
    input logic       mem_rsp_valid
);

    int err_count = 0;
    int fetch_outstanding;
    int mem_outstanding;

    // Independent credit tracking from the port pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_outstanding <= 0;
            mem_outstanding   <= 0;
        end else begin
            fetch_outstanding <= fetch_outstanding + int'(req_valid) - int'(req_credit);
            mem_outstanding   <= mem_outstanding + int'(mem_req_valid) - int'(mem_rsp_valid);
        end
    end

    mem_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> mem_outstanding < `IMMU_MEM_CREDITS)
        else begin
            $error("memory read issued with no memory credit left");
            err_count++;
        end

    fetch_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_outstanding <= `IMMU_REQ_CREDITS)
        else begin
            $error("outstanding fetch requests exceed the request credits");
            err_count++;
        end

    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |-> !rsp_valid && !req_credit && !mem_req_valid)
        else begin
            $error("output active during reset");
            err_count++;
        end

    fault_ppn_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp.page_fault |-> rsp.ppn == '0)
        else begin
            $error("faulting response carries a physical page");
            err_count++;
        end

endmodule

//--- verif/immu_tb.sv
`include "immu_settings.svh"

module immu_tb
    import immu_pkg::*;
();

    localparam int          TIMEOUT = 200;
    localparam logic [7:0]  F_V     = 8'h01;
    localparam logic [7:0]  F_R     = 8'h02;
    localparam logic [7:0]  F_W     = 8'h04;
    localparam logic [7:0]  F_X     = 8'h08;
    localparam logic [21:0] ROOT    = 22'h1;  // Root table at 0x1000
    localparam logic [21:0] L0_PPN  = 22'h2;  // Level 0 table at 0x2000

    logic        clk;
    logic        rst_n;
    logic [21:0] satp_ppn;
    logic        flush;
    logic        req_valid;
    xlate_req_t  req;
    logic        req_credit;
    logic        rsp_valid;
    xlate_rsp_t  rsp;
    logic        mem_req_valid;
    mem_rd_req_t mem_req;
    logic        mem_rsp_valid;
    mem_rd_rsp_t mem_rsp;

    int          errors = 0;
    int          errs_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          sent = 0;
    int          credits_back = 0;
    int          mem_reads = 0;
    int          last_lat = 0;
    logic [33:0] rd_addrs [$];  // Every address the walker read
    string       cur_test;

    immu_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .satp_ppn      (satp_ppn),
        .flush         (flush),
        .req_valid     (req_valid),
        .req           (req),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    immu_mem_model u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    bind immu_top immu_properties u_props (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_valid (mem_rsp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (req_credit) credits_back <= credits_back + 1;
        if (mem_req_valid) begin
            mem_reads <= mem_reads + 1;  // Walker traffic seen at the port
            rd_addrs.push_back(mem_req.addr);
        end
    end

    // Sv32 entry address inside a table page
    function automatic logic [33:0] pte_addr(input logic [21:0] table_ppn,
                                             input logic [9:0] index);
        return {table_ppn, 12'h000} + 34'({index, 2'b00});
    endfunction

    task automatic set_pte(input logic [33:0] addr, input logic [21:0] ppn,
                           input logic [7:0] flags);
        u_mem.write_word(addr, {ppn, 2'b00, flags});
    endtask

    task automatic check(input string what, input logic [33:0] expected,
                         input logic [33:0] actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d error(s)", cur_test, errors - errs_at_start);
        end
    endtask

    task automatic send_req(input logic [19:0] page, input logic [3:0] id);
        int waited;
        waited = 0;
        while ((sent - credits_back) >= `IMMU_REQ_CREDITS && waited < TIMEOUT) begin
            @(posedge clk);
            req_valid <= 1'b0;
            waited++;
        end
        if (waited >= TIMEOUT) begin
            $display("%s: no request credit came back within %0d cycles", cur_test, TIMEOUT);
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{vpn: page, tag: id};
        sent++;
    endtask

    // Counts the cycles from req_valid to rsp_valid
    task automatic wait_rsp(output xlate_rsp_t got, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        got    = '0;
        while (!ok && cycles <= TIMEOUT) begin
            @(posedge clk);
            req_valid <= 1'b0;
            if (rsp_valid) begin
                ok  = 1'b1;
                got = rsp;
            end else begin
                cycles++;
            end
        end
        last_lat = cycles;
        if (!ok) begin
            $display("%s: no response within %0d cycles", cur_test, TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_xlate(input logic [19:0] page, input logic [3:0] id,
                             input logic [21:0] exp_ppn, input logic exp_fault,
                             input logic exp_4m, input int exp_reads);
        xlate_rsp_t got;
        bit         ok;
        int         reads_before;
        reads_before = mem_reads;
        send_req(page, id);
        wait_rsp(got, ok);
        if (ok) begin
            check("tag", id, got.tag);
            check("ppn", exp_ppn, got.ppn);
            check("page_fault", exp_fault, got.page_fault);
            check("page_4m", exp_4m, got.page_4m);
            check("memory reads", exp_reads, mem_reads - reads_before);
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin
        logic [21:0] leaf_a;
        logic [21:0] leaf_b;
        logic [21:0] sp_ppn;
        xlate_rsp_t  got;
        bit          ok;
        int          back_before;
        int          reads_before;
        int          waited;
        int          first_rd;

        rst_n     = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        satp_ppn  = ROOT;

        void'($urandom(32'h8db5));
        leaf_a = 22'h100 | 22'($urandom & 32'hff);
        leaf_b = 22'h200 | 22'($urandom & 32'hff);
        sp_ppn = {12'($urandom) | 12'h800, 10'h000};  // 4 MiB aligned

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        set_pte(pte_addr(ROOT, 10'h001), L0_PPN, F_V);  // Pointer to level 0
        set_pte(pte_addr(ROOT, 10'h006), sp_ppn, F_X | F_R | F_V);
        set_pte(pte_addr(L0_PPN, 10'h005), leaf_a, F_X | F_R | F_V);
        set_pte(pte_addr(L0_PPN, 10'h00c), leaf_b, F_X | F_V);
        set_pte(pte_addr(L0_PPN, 10'h009), 22'($urandom), F_R | F_V);  // Not executable
        set_pte(pte_addr(L0_PPN, 10'h00a), 22'($urandom), F_W | F_X | F_V);
        // Root entry 3 left at zero

        begin_test("walk_4k");
        first_rd = rd_addrs.size();
        run_xlate({10'h001, 10'h005}, 4'h1, leaf_a, 1'b0, 1'b0, 2);
        check("level 1 address", pte_addr(ROOT, 10'h001), rd_addrs[first_rd]);
        check("level 0 address", pte_addr(L0_PPN, 10'h005), rd_addrs[first_rd + 1]);
        end_test();

        begin_test("hit_4k");
        run_xlate({10'h001, 10'h005}, 4'h2, leaf_a, 1'b0, 1'b0, 0);
        check("latency", 2, last_lat);
        end_test();

        begin_test("superpage_4m");
        first_rd = rd_addrs.size();
        run_xlate({10'h006, 10'h123}, 4'h3, {sp_ppn[21:10], 10'h123}, 1'b0, 1'b1, 1);
        check("level 1 address", pte_addr(ROOT, 10'h006), rd_addrs[first_rd]);
        run_xlate({10'h006, 10'h2a7}, 4'h4, {sp_ppn[21:10], 10'h2a7}, 1'b0, 1'b1, 0);
        end_test();

        // Retries walk again since faults never fill
        begin_test("fault_invalid");
        run_xlate({10'h003, 10'h010}, 4'h5, 22'h0, 1'b1, 1'b0, 1);
        run_xlate({10'h003, 10'h010}, 4'h6, 22'h0, 1'b1, 1'b0, 1);
        end_test();

        begin_test("fault_no_x");
        run_xlate({10'h001, 10'h009}, 4'h7, 22'h0, 1'b1, 1'b0, 2);
        run_xlate({10'h001, 10'h009}, 4'h8, 22'h0, 1'b1, 1'b0, 2);
        end_test();

        begin_test("fault_w_no_r");
        run_xlate({10'h001, 10'h00a}, 4'h9, 22'h0, 1'b1, 1'b0, 2);
        run_xlate({10'h001, 10'h00a}, 4'ha, 22'h0, 1'b1, 1'b0, 2);
        end_test();

        begin_test("flush_rewalk");
        pulse_flush();
        run_xlate({10'h001, 10'h005}, 4'hb, leaf_a, 1'b0, 1'b0, 2);
        end_test();

        begin_test("back_to_back");
        back_before  = credits_back;
        reads_before = mem_reads;
        send_req({10'h001, 10'h00c}, 4'hc);
        send_req({10'h006, 10'h055}, 4'hd);  // Superpage was flushed
        wait_rsp(got, ok);
        if (ok) begin
            check("first tag", 4'hc, got.tag);
            check("first ppn", leaf_b, got.ppn);
        end
        wait_rsp(got, ok);
        if (ok) begin
            check("second tag", 4'hd, got.tag);
            check("second ppn", {sp_ppn[21:10], 10'h055}, got.ppn);
            check("second page_4m", 1'b1, got.page_4m);
        end
        waited = 0;
        while ((credits_back - back_before) < 2 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        check("credits returned", 2, credits_back - back_before);
        check("memory reads", 3, mem_reads - reads_before);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors,
                 DUT.u_props.err_count);
        if (errors == 0 && tests_failed == 0 && DUT.u_props.err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
